/* include/ntm_params.svh */
// Logarithm unit widths

`ifndef NTM_PARAMS_SVH
`define NTM_PARAMS_SVH

//////////////////////////////
// Word widths
//////////////////////////////

// Width of every data and size word
`define NTM_DATA_SIZE 16

// Running power of the scalar core
// Twice the data width so one multiply by the base cannot overflow
`define NTM_PRODUCT_SIZE (2 * `NTM_DATA_SIZE)

`endif

/* project.f */
+incdir+include
verilog/ntm_pkg.sv
verilog/ntm_scalar_logarithm.sv
verilog/ntm_vector_logarithm.sv
verilog/ntm_matrix_logarithm.sv
testbench/ntm_logarithm_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the matrix logarithm testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing \
  -f project.f \
  --top-module ntm_logarithm_tb \
  -o sim_ntm_logarithm

output="$(./obj_dir/sim_ntm_logarithm)"
echo "$output"

# Pass only when the testbench printed its pass line
if grep -q "Test completed successfully" <<< "$output"; then
  exit 0
fi
exit 1

/* testbench/ntm_logarithm_tb.sv */
// Matrix logarithm testbench

`include "ntm_params.svh"

module ntm_logarithm_tb
  import ntm_pkg::*;
();

  //////////////////////////////
  // Constants
  //////////////////////////////

  localparam int CLK_PERIOD = 8;
  localparam int SEED       = 51439;
  localparam int DATA_MAX   = (1 << `NTM_DATA_SIZE) - 1;

  // Element count over all runs and worst-case cycles per element
  localparam int TOTAL_ELEMENTS = 34;
  localparam int CYCLE_BOUND    = 64;
  localparam int MARGIN_CYCLES  = 400;
  localparam int WATCHDOG_TIME  =
    (TOTAL_ELEMENTS * CYCLE_BOUND + MARGIN_CYCLES) * CLK_PERIOD;

  // Operand strobe orders
  localparam int ORDER_A_FIRST = 0;
  localparam int ORDER_B_FIRST = 1;
  localparam int ORDER_SAME    = 2;
  localparam int ORDER_CYCLE   = 3;

  //////////////////////////////
  // DUT signals
  //////////////////////////////

  logic            CLK;
  logic            RST;
  logic            start;
  ntm_word_t       size_i;
  ntm_word_t       size_j;
  logic            a_enable;
  logic            b_enable;
  ntm_word_t       data_a;
  ntm_word_t       data_b;
  ntm_word_t       modulo;
  logic            out_enable;
  ntm_log_result_t data_out;
  logic            ready;

  // Stimulus and expected results from the main process
  ntm_log_operands_t stim_q[$];
  ntm_log_result_t   expected_q[$];

  // Monitor side bookkeeping
  int check_index    = 0;
  int total_outputs  = 0;
  int ready_pulses   = 0;
  int monitor_errors = 0;

  // Main side bookkeeping
  int driver_errors = 0;
  int pass_count    = 0;
  int fail_count    = 0;

  ntm_matrix_logarithm u_ntm_matrix_logarithm (
    .CLK              (CLK),
    .RST              (RST),
    .START            (start),
    .SIZE_I_IN        (size_i),
    .SIZE_J_IN        (size_j),
    .DATA_A_IN_ENABLE (a_enable),
    .DATA_B_IN_ENABLE (b_enable),
    .DATA_A_IN        (data_a),
    .DATA_B_IN        (data_b),
    .MODULO_IN        (modulo),
    .DATA_OUT_ENABLE  (out_enable),
    .DATA_OUT         (data_out),
    .READY            (ready)
  );

  always #(CLK_PERIOD / 2) CLK = ~CLK;

  //////////////////////////////
  // Reference model
  //////////////////////////////

  // Largest k with base**k <= data_a, then reduced by modulo
  function automatic ntm_word_t log_model(input ntm_log_operands_t op);
    longint power;
    longint base;
    longint limit;
    int     count;
    base  = longint'(op.data_b);
    limit = longint'(op.data_a);
    count = 0;
    if (base >= 2 && limit != 0) begin
      power = base;
      while (power <= limit) begin
        count++;
        power = power * base;
      end
    end
    // modulo 0 passes the raw count
    if (op.modulo != '0) begin
      count = count % int'(op.modulo);
    end
    return ntm_word_t'(count);
  endfunction

  function automatic ntm_log_operands_t make_operands(input int mod_value, input int a_value,
                                                      input int b_value);
    ntm_log_operands_t op;
    op.modulo = ntm_word_t'(mod_value);
    op.data_a = ntm_word_t'(a_value);
    op.data_b = ntm_word_t'(b_value);
    return op;
  endfunction

  // Base from 2 to 16 with any argument
  function automatic ntm_log_operands_t random_operands(input int max_modulo);
    return make_operands(int'($urandom_range(max_modulo, 0)),
                         int'($urandom_range(DATA_MAX, 0)),
                         int'($urandom_range(16, 2)));
  endfunction

  //////////////////////////////
  // Compare tasks
  //////////////////////////////

  task automatic check_result(input ntm_log_result_t got, input ntm_log_result_t exp);
    if (got.value !== exp.value) begin
      $display("Error at %0t: DATA_OUT.value = %0d, expected %0d", $time, got.value, exp.value);
      monitor_errors++;
    end
    if (got.row !== exp.row) begin
      $display("Error at %0t: DATA_OUT.row = %0d, expected %0d", $time, got.row, exp.row);
      monitor_errors++;
    end
    if (got.column !== exp.column) begin
      $display("Error at %0t: DATA_OUT.column = %0d, expected %0d", $time, got.column,
               exp.column);
      monitor_errors++;
    end
  endtask

  // READY must close the run on its last result
  task automatic check_done(input ntm_word_t got_count, input ntm_word_t exp_count,
                            input logic with_enable);
    if (got_count !== exp_count) begin
      $display("Error at %0t: result count at READY = %0d, expected %0d", $time, got_count,
               exp_count);
      monitor_errors++;
    end
    if (with_enable !== 1'b1) begin
      $display("Error at %0t: DATA_OUT_ENABLE with READY = %0b, expected 1", $time,
               with_enable);
      monitor_errors++;
    end
  endtask

  //////////////////////////////
  // Output monitor
  //////////////////////////////

  // Sampled away from the rising edge
  always @(negedge CLK) begin
    if (!RST) begin
      if (out_enable) begin
        if (check_index >= expected_q.size()) begin
          $display("DATA_OUT_ENABLE pulsed at %0t with no result pending", $time);
          monitor_errors++;
        end else begin
          check_result(data_out, expected_q[check_index]);
          check_index++;
        end
        total_outputs++;
      end
      if (ready) begin
        ready_pulses++;
        check_done(ntm_word_t'(total_outputs), ntm_word_t'(expected_q.size()), out_enable);
      end
    end
  end

  //////////////////////////////
  // Driver tasks
  //////////////////////////////

  task automatic next_cycle();
    @(posedge CLK);
    #1;
  endtask

  task automatic apply_operands(input ntm_log_operands_t op, input int mode);
    data_a = op.data_a;
    data_b = op.data_b;
    modulo = op.modulo;
    case (mode)
      ORDER_A_FIRST: begin
        a_enable = 1'b1;
        next_cycle();
        a_enable = 1'b0;
        b_enable = 1'b1;
      end
      ORDER_B_FIRST: begin
        b_enable = 1'b1;
        next_cycle();
        b_enable = 1'b0;
        a_enable = 1'b1;
      end
      default: begin
        a_enable = 1'b1;
        b_enable = 1'b1;
      end
    endcase
    next_cycle();
    a_enable = 1'b0;
    b_enable = 1'b0;
  endtask

  // Strobes for the next element only once the sequencer is gathering again
  task automatic wait_outputs(input int target);
    while (total_outputs < target) @(posedge CLK);
    next_cycle();
  endtask

  // One matrix pass over operands taken from stim_q in row-major order
  task automatic run_matrix(input int rows, input int cols, input int order_mode,
                            input int idle_cycles);
    ntm_log_operands_t ops[$];
    ntm_log_result_t   exp;
    int                outputs_before;
    int                ready_before;
    int                mode;
    outputs_before = total_outputs;
    ready_before   = ready_pulses;
    for (int e = 0; e < rows * cols; e++) begin
      ops.push_back(stim_q.pop_front());
      exp.value  = log_model(ops[e]);
      exp.row    = ntm_word_t'(e / cols);
      exp.column = ntm_word_t'(e % cols);
      expected_q.push_back(exp);
    end
    start  = 1'b1;
    size_i = ntm_word_t'(rows);
    size_j = ntm_word_t'(cols);
    next_cycle();
    start = 1'b0;
    next_cycle();
    next_cycle();
    for (int e = 0; e < rows * cols; e++) begin
      mode = (order_mode == ORDER_CYCLE) ? e % 3 : order_mode;
      apply_operands(ops[e], mode);
      wait_outputs(outputs_before + e + 1);
    end
    repeat (idle_cycles) next_cycle();
    if (ready_pulses - ready_before != 1) begin
      $display("READY pulsed %0d times during a %0dx%0d run instead of once",
               ready_pulses - ready_before, rows, cols);
      driver_errors++;
    end
    if (total_outputs - outputs_before != rows * cols) begin
      $display("A %0dx%0d run gave %0d results", rows, cols, total_outputs - outputs_before);
      driver_errors++;
    end
  endtask

  task automatic report_test(input int number, input string name, input int errors_before);
    int new_errors;
    new_errors = monitor_errors + driver_errors - errors_before;
    if (new_errors == 0) begin
      pass_count++;
      $display("[%0t] test %0d %s: passed", $time, number, name);
    end else begin
      fail_count++;
      $display("[%0t] test %0d %s: FAILED with %0d errors", $time, number, name, new_errors);
    end
  endtask

  //////////////////////////////
  // Watchdog
  //////////////////////////////

  initial begin
    #(WATCHDOG_TIME);
    $display("Run timed out at %0t before all results arrived", $time);
    $display("Test failed");
    $finish;
  end

  //////////////////////////////
  // Test sequence
  //////////////////////////////

  initial begin
    int errors_before;
    void'($urandom(SEED));
    CLK      = 1'b0;
    RST      = 1'b1;
    start    = 1'b0;
    size_i   = '0;
    size_j   = '0;
    a_enable = 1'b0;
    b_enable = 1'b0;
    data_a   = '0;
    data_b   = '0;
    modulo   = '0;
    repeat (4) @(posedge CLK);
    #1;
    RST = 1'b0;
    next_cycle();

    // Single element
    errors_before = monitor_errors + driver_errors;
    stim_q.push_back(random_operands(7));
    run_matrix(1, 1, ORDER_SAME, 4);
    report_test(1, "single 1x1 element", errors_before);

    // Base 0, base 1, zero argument, then modulo 0
    errors_before = monitor_errors + driver_errors;
    stim_q.push_back(make_operands(5, 100, 0));
    stim_q.push_back(make_operands(5, 100, 1));
    stim_q.push_back(make_operands(3, 0, 7));
    stim_q.push_back(make_operands(0, 60000, 3));
    run_matrix(1, 4, ORDER_SAME, 4);
    report_test(2, "degenerate operands", errors_before);

    errors_before = monitor_errors + driver_errors;
    repeat (12) stim_q.push_back(random_operands(7));
    run_matrix(3, 4, ORDER_A_FIRST, 4);
    report_test(3, "random 3x4 matrix", errors_before);

    // A first, B first and same cycle in turn
    errors_before = monitor_errors + driver_errors;
    repeat (6) stim_q.push_back(random_operands(5));
    run_matrix(2, 3, ORDER_CYCLE, 4);
    report_test(4, "strobe ordering", errors_before);

    // Long idle tail catches late or repeated READY pulses
    errors_before = monitor_errors + driver_errors;
    repeat (4) stim_q.push_back(random_operands(7));
    run_matrix(2, 2, ORDER_B_FIRST, 20);
    report_test(5, "single READY per run", errors_before);

    errors_before = monitor_errors + driver_errors;
    repeat (7) stim_q.push_back(random_operands(7));
    run_matrix(2, 2, ORDER_SAME, 0);
    run_matrix(1, 3, ORDER_A_FIRST, 4);
    report_test(6, "back-to-back runs", errors_before);

    if (check_index != expected_q.size()) begin
      $display("%0d expected results never arrived", expected_q.size() - check_index);
      driver_errors++;
    end
    $display("Summary: %0d passed, %0d failing, %0d errors", pass_count, fail_count,
             monitor_errors + driver_errors);
    if (fail_count == 0 && monitor_errors + driver_errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

/* verilog/ntm_matrix_logarithm.sv */
// Matrix logarithm top level

`include "ntm_params.svh"

module ntm_matrix_logarithm
  import ntm_pkg::*;
(
  // Global
  input  logic            CLK,
  input  logic            RST,
  // Control
  input  logic            START,
  input  ntm_word_t       SIZE_I_IN,
  input  ntm_word_t       SIZE_J_IN,
  input  logic            DATA_A_IN_ENABLE,
  input  logic            DATA_B_IN_ENABLE,
  // Data
  input  ntm_word_t       DATA_A_IN,
  input  ntm_word_t       DATA_B_IN,
  input  ntm_word_t       MODULO_IN,
  // Outputs
  output logic            DATA_OUT_ENABLE,
  output ntm_log_result_t DATA_OUT,
  output logic            READY
);

  //////////////////////////////
  // Types
  //////////////////////////////

  typedef enum logic {
    STARTER_STATE,
    ENDER_STATE
  } matrix_state_t;

  //////////////////////////////
  // Signals
  //////////////////////////////

  matrix_state_t state_r;

  // Row counter and final row
  ntm_word_t row_r;
  ntm_word_t last_row_r;
  logic      last_row;

  // Row length held for every vector pass
  ntm_word_t size_j_r;

  // Vector sequencer link
  logic      vec_start_r;
  logic      vec_enable;
  ntm_word_t vec_data;
  ntm_word_t vec_index;
  logic      vec_ready;
  logic      row_done;

  assign last_row = (row_r == last_row_r);
  assign row_done = (state_r == ENDER_STATE) && vec_ready;

  //////////////////////////////
  // Row FSM
  //////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state_r         <= STARTER_STATE;
      row_r           <= '0;
      last_row_r      <= '0;
      size_j_r        <= '0;
      vec_start_r     <= 1'b0;
      DATA_OUT_ENABLE <= 1'b0;
      READY           <= 1'b0;
    end else begin
      vec_start_r <= 1'b0;
      READY       <= 1'b0;
      // Element strobe follows the vector one cycle later
      DATA_OUT_ENABLE <= vec_enable;
      case (state_r)
        STARTER_STATE: begin
          if (START) begin
            row_r <= '0;
            // Zero rows behaves as a single row
            last_row_r  <= (SIZE_I_IN == '0) ? '0 : SIZE_I_IN - ntm_word_t'(1);
            size_j_r    <= SIZE_J_IN;
            vec_start_r <= 1'b1;
            state_r     <= ENDER_STATE;
          end
        end
        ENDER_STATE: begin
          if (row_done) begin
            if (last_row) begin
              // Lines up with the final element strobe
              READY   <= 1'b1;
              state_r <= STARTER_STATE;
            end else begin
              // Next row straight after the vector finishes
              row_r       <= row_r + ntm_word_t'(1);
              vec_start_r <= 1'b1;
            end
          end
        end
        default: begin
          state_r <= STARTER_STATE;
        end
      endcase
    end
  end

  //////////////////////////////
  // Result packing
  //////////////////////////////

  // Row still holds the current value while the vector output is up
  always_ff @(posedge CLK) begin
    if (vec_enable) begin
      DATA_OUT <= '{value: vec_data, row: row_r, column: vec_index};
    end
  end

  // One row per pass
  ntm_vector_logarithm u_ntm_vector_logarithm (
    .CLK              (CLK),
    .RST              (RST),
    .START            (vec_start_r),
    .SIZE_IN          (size_j_r),
    .DATA_A_IN_ENABLE (DATA_A_IN_ENABLE),
    .DATA_B_IN_ENABLE (DATA_B_IN_ENABLE),
    .DATA_A_IN        (DATA_A_IN),
    .DATA_B_IN        (DATA_B_IN),
    .MODULO_IN        (MODULO_IN),
    .DATA_OUT_ENABLE  (vec_enable),
    .DATA_OUT         (vec_data),
    .INDEX_OUT        (vec_index),
    .READY            (vec_ready)
  );

endmodule

/* verilog/ntm_pkg.sv */
// Logarithm unit shared types

`include "ntm_params.svh"

package ntm_pkg;

  //////////////////////////////
  // Scalar words
  //////////////////////////////

  // Operands, modulo, sizes and results
  typedef logic [`NTM_DATA_SIZE-1:0] ntm_word_t;

  //////////////////////////////
  // Bundles
  //////////////////////////////

  // One element pair plus its modulo, into the scalar core
  typedef struct packed {
    ntm_word_t modulo;
    ntm_word_t data_a;
    ntm_word_t data_b;
  } ntm_log_operands_t;

  // Result word tagged with its matrix position
  typedef struct packed {
    ntm_word_t value;
    ntm_word_t row;
    ntm_word_t column;
  } ntm_log_result_t;

endpackage

/* verilog/ntm_scalar_logarithm.sv */
// Scalar integer logarithm core

`include "ntm_params.svh"

module ntm_scalar_logarithm
  import ntm_pkg::*;
(
  // Global
  input  logic              CLK,
  input  logic              RST,
  // Control
  input  logic              START,
  // Data
  input  ntm_log_operands_t OPERANDS,
  // Control
  output logic              READY,
  // Data
  output ntm_word_t         DATA_OUT
);

  //////////////////////////////
  // Types and constants
  //////////////////////////////

  typedef enum logic [1:0] {
    IDLE_STATE,
    CHECK_STATE,
    POWER_STATE,
    REDUCE_STATE
  } scalar_state_t;

  // Zero padding from data width up to product width
  localparam int PAD_SIZE = `NTM_PRODUCT_SIZE - `NTM_DATA_SIZE;

  //////////////////////////////
  // Signals
  //////////////////////////////

  scalar_state_t state_r;

  // Registered operand pair
  ntm_log_operands_t operands_r;

  // Running power of the base and its exponent
  logic [`NTM_PRODUCT_SIZE-1:0] power_r;
  ntm_word_t                    count_r;

  // Operands widened to product width
  logic [`NTM_PRODUCT_SIZE-1:0] base_ext;
  logic [`NTM_PRODUCT_SIZE-1:0] limit_ext;

  // Loop decisions
  logic degenerate;
  logic power_fits;
  logic reduce_step;

  //////////////////////////////
  // Decisions
  //////////////////////////////

  assign base_ext  = {{PAD_SIZE{1'b0}}, operands_r.data_b};
  assign limit_ext = {{PAD_SIZE{1'b0}}, operands_r.data_a};

  // Base below 2 or zero argument gives a zero count
  assign degenerate = (operands_r.data_b < ntm_word_t'(2)) || (operands_r.data_a == '0);

  // Next power still at or below data_a
  assign power_fits = (power_r <= limit_ext);

  // Modulo 0 leaves the count unreduced
  assign reduce_step = (operands_r.modulo != '0) && (count_r >= operands_r.modulo);

  //////////////////////////////
  // Control FSM
  //////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state_r <= IDLE_STATE;
      READY   <= 1'b0;
    end else begin
      // Single-cycle pulse by default
      READY <= 1'b0;
      case (state_r)
        IDLE_STATE: begin
          if (START) begin
            state_r <= CHECK_STATE;
          end
        end
        CHECK_STATE: begin
          // Skip the power loop for degenerate pairs
          if (degenerate) begin
            state_r <= REDUCE_STATE;
          end else begin
            state_r <= POWER_STATE;
          end
        end
        POWER_STATE: begin
          if (!power_fits) begin
            state_r <= REDUCE_STATE;
          end
        end
        REDUCE_STATE: begin
          // Result is final once no further subtraction applies
          if (!reduce_step) begin
            READY   <= 1'b1;
            state_r <= IDLE_STATE;
          end
        end
        default: begin
          state_r <= IDLE_STATE;
        end
      endcase
    end
  end

  //////////////////////////////
  // Datapath
  //////////////////////////////

  always_ff @(posedge CLK) begin
    case (state_r)
      IDLE_STATE: begin
        if (START) begin
          operands_r <= OPERANDS;
        end
      end
      CHECK_STATE: begin
        // First candidate is base to the power 1
        power_r <= base_ext;
        count_r <= '0;
      end
      POWER_STATE: begin
        if (power_fits) begin
          count_r <= count_r + ntm_word_t'(1);
          power_r <= power_r * base_ext;
        end
      end
      REDUCE_STATE: begin
        // Repeated subtraction of modulo
        if (reduce_step) begin
          count_r <= count_r - operands_r.modulo;
        end else begin
          DATA_OUT <= count_r;
        end
      end
      default: begin
        count_r <= '0;
      end
    endcase
  end

endmodule

/* verilog/ntm_vector_logarithm.sv */
// Vector logarithm sequencer

`include "ntm_params.svh"

module ntm_vector_logarithm
  import ntm_pkg::*;
(
  // Global
  input  logic      CLK,
  input  logic      RST,
  // Control
  input  logic      START,
  input  ntm_word_t SIZE_IN,
  input  logic      DATA_A_IN_ENABLE,
  input  logic      DATA_B_IN_ENABLE,
  // Data
  input  ntm_word_t DATA_A_IN,
  input  ntm_word_t DATA_B_IN,
  input  ntm_word_t MODULO_IN,
  // Outputs
  output logic      DATA_OUT_ENABLE,
  output ntm_word_t DATA_OUT,
  output ntm_word_t INDEX_OUT,
  output logic      READY
);

  //////////////////////////////
  // Types
  //////////////////////////////

  typedef enum logic [1:0] {
    STARTER_STATE,
    INPUT_STATE,
    ENDER_STATE
  } vector_state_t;

  //////////////////////////////
  // Signals
  //////////////////////////////

  vector_state_t state_r;

  // Element index and final index of this pass
  ntm_word_t element_r;
  ntm_word_t last_index_r;

  // Operand presence flags
  logic a_valid_r;
  logic b_valid_r;
  logic both_valid;

  // Strobe qualification
  logic latch_a;
  logic latch_b;
  logic launch;
  logic element_done;

  // Scalar core link
  logic              core_start_r;
  logic              core_ready;
  ntm_log_operands_t operands_r;
  ntm_word_t         core_data;

  //////////////////////////////
  // Strobe handling
  //////////////////////////////

  assign both_valid = a_valid_r && b_valid_r;

  // Strobes only count while gathering, and not once the pair is complete
  assign latch_a = (state_r == INPUT_STATE) && DATA_A_IN_ENABLE && !both_valid;
  assign latch_b = (state_r == INPUT_STATE) && DATA_B_IN_ENABLE && !both_valid;

  assign launch       = (state_r == INPUT_STATE) && both_valid;
  assign element_done = (state_r == ENDER_STATE) && core_ready;

  //////////////////////////////
  // Control FSM
  //////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state_r         <= STARTER_STATE;
      element_r       <= '0;
      last_index_r    <= '0;
      a_valid_r       <= 1'b0;
      b_valid_r       <= 1'b0;
      core_start_r    <= 1'b0;
      DATA_OUT_ENABLE <= 1'b0;
      READY           <= 1'b0;
    end else begin
      // Pulses
      core_start_r    <= 1'b0;
      DATA_OUT_ENABLE <= 1'b0;
      READY           <= 1'b0;
      case (state_r)
        STARTER_STATE: begin
          if (START) begin
            element_r <= '0;
            // Size 0 runs one element
            last_index_r <= (SIZE_IN == '0) ? '0 : SIZE_IN - ntm_word_t'(1);
            state_r      <= INPUT_STATE;
          end
        end
        INPUT_STATE: begin
          if (latch_a) begin
            a_valid_r <= 1'b1;
          end
          if (latch_b) begin
            b_valid_r <= 1'b1;
          end
          // Pair complete, start the core
          if (launch) begin
            a_valid_r    <= 1'b0;
            b_valid_r    <= 1'b0;
            core_start_r <= 1'b1;
            state_r      <= ENDER_STATE;
          end
        end
        ENDER_STATE: begin
          if (element_done) begin
            DATA_OUT_ENABLE <= 1'b1;
            if (element_r == last_index_r) begin
              READY   <= 1'b1;
              state_r <= STARTER_STATE;
            end else begin
              element_r <= element_r + ntm_word_t'(1);
              state_r   <= INPUT_STATE;
            end
          end
        end
        default: begin
          state_r <= STARTER_STATE;
        end
      endcase
    end
  end

  //////////////////////////////
  // Operand and result registers
  //////////////////////////////

  always_ff @(posedge CLK) begin
    if (latch_a) begin
      operands_r.data_a <= DATA_A_IN;
    end
    if (latch_b) begin
      operands_r.data_b <= DATA_B_IN;
    end
    // Modulo taken once both operands are present
    if (launch) begin
      operands_r.modulo <= MODULO_IN;
    end
    if (element_done) begin
      DATA_OUT  <= core_data;
      INDEX_OUT <= element_r;
    end
  end

  // One element at a time
  ntm_scalar_logarithm u_ntm_scalar_logarithm (
    .CLK      (CLK),
    .RST      (RST),
    .START    (core_start_r),
    .OPERANDS (operands_r),
    .READY    (core_ready),
    .DATA_OUT (core_data)
  );

endmodule
